/* include/jls_tb_model.svh */
// Reference arithmetic for the context modeler testbench.
// Included inside the testbench module, which imports jls_pkg.
// Integer versions of the gradient, MED and modulo rules.

`ifndef JLS_TB_MODEL_SVH
`define JLS_TB_MODEL_SVH

// one gradient into -4..4, sign follows the gradient
function automatic int grad_region(input int g);
    int m;
    int r;
    m = (g < 0) ? -g : g;
    if (m == 0) r = 0;
    else if (m < GRAD_T1) r = 1;
    else if (m < GRAD_T2) r = 2;
    else if (m < GRAD_T3) r = 3;
    else r = 4;
    return (g < 0) ? -r : r;
endfunction

// signed context from the three gradients d-b, b-c, c-a
function automatic int signed_context(input int a, input int b, input int c, input int d);
    return 81 * grad_region(d - b) + 9 * grad_region(b - c) + grad_region(c - a);
endfunction

// median edge detector
function automatic int med_value(input int a, input int b, input int c);
    int hi;
    int lo;
    hi = (a > b) ? a : b;
    lo = (a > b) ? b : a;
    if (c >= hi) return lo;     // edge above or left
    if (c <= lo) return hi;
    return a + b - c;           // smooth area, planar value
endfunction

// fold any error into -128..127
function automatic int wrap_error(input int e);
    int r;
    r = ((e % ERR_RANGE) + ERR_RANGE) % ERR_RANGE;   // 0..255 first
    if (r >= ERR_HALF) r = r - ERR_RANGE;
    return r;
endfunction

`endif

/* bench/tb_jls_context_modeler.sv */
// Self-checking testbench for the JPEG-LS context modeler.
// Streams a table of small images through the DUT, predicts each result
// from the stored image and compares all fields plus the 4-cycle latency.

`timescale 1ns/1ps
`default_nettype none

module tb_jls_context_modeler
    import jls_pkg::*;
();

    localparam int MAX_ROWS      = 8;
    localparam int MAX_COLS      = 16;
    localparam int NUM_TESTS     = 8;
    localparam int LATENCY       = 4;     // i_valid to o_valid
    localparam int DRAIN_TIMEOUT = 200;   // cycles
    localparam int SETTLE_CYCLES = 8;
    localparam int RAMP_BASE     = 40;

    localparam logic [1:0] KIND_FLAT  = 2'd0;
    localparam logic [1:0] KIND_HRAMP = 2'd1;
    localparam logic [1:0] KIND_VRAMP = 2'd2;
    localparam logic [1:0] KIND_RAND  = 2'd3;

    typedef struct packed {
        logic [COORD_W-1:0] w_m1;
        logic [COORD_W-1:0] h_m1;
        logic [1:0]         kind;
        logic [PIXEL_W-1:0] param;   // flat value or ramp step
        logic [3:0]         extra;   // pixels sent past the last row
    } test_row_t;

    logic               clk;
    logic               reset;
    logic               i_sof;
    logic [COORD_W-1:0] i_w;
    logic [COORD_W-1:0] i_h;
    logic               i_valid;
    logic [PIXEL_W-1:0] i_x;
    logic               o_valid;
    ctx_result_t        o_res;

    test_row_t   tests [NUM_TESTS];
    string       test_names [NUM_TESTS];
    int          image [MAX_ROWS][MAX_COLS];
    ctx_result_t exp_q [$];     // expected records, raster order
    int          due_q [$];     // expected output cycle per pixel
    logic [31:0] lfsr_state;
    string       cur_test;
    int          cycle;
    int          errors;
    int          checks;
    int          tests_run;
    int          out_count;
    int          last_count;

    `include "jls_tb_model.svh"

    jls_context_modeler i_jls_context_modeler (
        .clk     (clk),
        .reset   (reset),
        .i_sof   (i_sof),
        .i_w     (i_w),
        .i_h     (i_h),
        .i_valid (i_valid),
        .i_x     (i_x),
        .o_valid (o_valid),
        .o_res   (o_res)
    );

    always #4 clk = ~clk;                    // 8 ns period
    always @(posedge clk) cycle <= cycle + 1;

    //------------------------------------------------------------
    // helpers
    //------------------------------------------------------------
    // taps 32,22,2,1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    function automatic int pattern_pixel(input test_row_t t, input int row, input int col);
        case (t.kind)
            KIND_FLAT:  return int'(t.param);
            KIND_HRAMP: return (RAMP_BASE + col * int'(t.param)) % 256;
            KIND_VRAMP: return (RAMP_BASE + row * int'(t.param)) % 256;
            default:    return rand_bits(PIXEL_W);
        endcase
    endfunction

    task automatic check_value(input string field, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("** Error %s %s: expected %0d, actual %0d",
                     cur_test, field, expected, actual);
        end
    endtask

    task automatic drive_slot(input logic valid, input int x);
        @(posedge clk);
        #1;
        i_sof   = 1'b0;
        i_valid = valid;
        i_x     = PIXEL_W'(x);
    endtask

    task automatic send_sof(input logic [COORD_W-1:0] w_m1, input logic [COORD_W-1:0] h_m1);
        @(posedge clk);
        #1;
        i_valid = 1'b0;                      // never together with i_sof
        i_sof   = 1'b1;
        i_w     = w_m1;
        i_h     = h_m1;
    endtask

    // neighbours by the edge rules, then context and error per pixel
    task automatic push_expected(input int w_eff, input int h_m1);
        int a;
        int b;
        int c;
        int d;
        int ctx;
        int err;
        ctx_result_t e;
        for (int r = 0; r <= h_m1; r++) begin
            for (int col = 0; col <= w_eff; col++) begin
                if (r == 0) begin
                    b = 0;
                    c = 0;
                    d = 0;
                end else begin
                    b = image[r-1][col];
                    if (col == 0) c = (r == 1) ? 0 : image[r-2][0];  // b of row above's start
                    else c = image[r-1][col-1];
                    d = (col == w_eff) ? b : image[r-1][col+1];
                end
                a = (col == 0) ? b : image[r][col-1];
                ctx = signed_context(a, b, c, d);
                err = image[r][col] - med_value(a, b, c);
                if (ctx < 0) err = -err;
                e.q      = CTX_W'((ctx < 0) ? -ctx : ctx);
                e.sign   = (ctx < 0);
                e.errval = PIXEL_W'(wrap_error(err));
                e.last   = (r == h_m1) && (col == w_eff);
                exp_q.push_back(e);
            end
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%s: timeout, %0d results never came out", cur_test, exp_q.size());
            exp_q.delete();
            due_q.delete();
        end
    endtask

    //------------------------------------------------------------
    // tests
    //------------------------------------------------------------
    task automatic run_pre_sof();
        cur_test  = "pre_sof";
        out_count = 0;
        for (int k = 0; k < 8; k++) drive_slot(1'b1, rand_bits(PIXEL_W));  // no image open
        drive_slot(1'b0, 0);
        repeat (SETTLE_CYCLES) @(posedge clk);
        check_value("outputs", 0, out_count);
        $display("%s: %0d results", cur_test, out_count);
        tests_run++;
    endtask

    task automatic run_test(input int n);
        test_row_t t;
        int w_eff;
        int pixels;
        int err_before;
        t          = tests[n];
        cur_test   = test_names[n];
        w_eff      = (t.w_m1 < MIN_W_M1) ? int'(MIN_W_M1) : int'(t.w_m1);  // narrow clamp
        pixels     = (w_eff + 1) * (int'(t.h_m1) + 1);
        err_before = errors;
        out_count  = 0;
        last_count = 0;
        for (int r = 0; r <= int'(t.h_m1); r++)
            for (int col = 0; col <= w_eff; col++) image[r][col] = pattern_pixel(t, r, col);
        push_expected(w_eff, int'(t.h_m1));
        send_sof(t.w_m1, t.h_m1);
        for (int r = 0; r <= int'(t.h_m1); r++) begin
            for (int col = 0; col <= w_eff; col++) begin
                if (rand_bits(3) == 0) drive_slot(1'b0, 0);   // occasional gap
                drive_slot(1'b1, image[r][col]);
                due_q.push_back(cycle + LATENCY);
            end
        end
        for (int k = 0; k < int'(t.extra); k++) drive_slot(1'b1, rand_bits(PIXEL_W));
        drive_slot(1'b0, 0);
        wait_drained();
        repeat (SETTLE_CYCLES) @(posedge clk);  // catch output from dropped pixels
        check_value("outputs", pixels, out_count);
        check_value("last flags", 1, last_count);
        $display("%s: %0d pixels, %0d results, %s", cur_test, pixels, out_count,
                 (errors == err_before) ? "ok" : "mismatch");
        tests_run++;
    endtask

    // result monitor, sampled mid-cycle
    always @(negedge clk) begin
        ctx_result_t want;
        int due;
        if (!reset && o_valid) begin
            out_count++;
            if (o_res.last) last_count++;
            if (exp_q.size() == 0 || due_q.size() == 0) begin
                errors++;
                $display("%s: DUT produced a result with no pixel pending", cur_test);
            end else begin
                want = exp_q.pop_front();
                due  = due_q.pop_front();
                check_value("q", int'(want.q), int'(o_res.q));
                check_value("sign", int'(want.sign), int'(o_res.sign));
                check_value("errval", int'($signed(want.errval)), int'($signed(o_res.errval)));
                check_value("last", int'(want.last), int'(o_res.last));
                check_value("cycle", due, cycle);
            end
        end
    end

    //------------------------------------------------------------
    // main sequence
    //------------------------------------------------------------
    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        i_sof      = 1'b0;
        i_w        = '0;
        i_h        = '0;
        i_valid    = 1'b0;
        i_x        = '0;
        cycle      = 0;
        errors     = 0;
        checks     = 0;
        tests_run  = 0;
        out_count  = 0;
        last_count = 0;
        lfsr_state = 32'haeb0_2855;

        // name, w-1, h-1, kind, value or step, extra pixels
        test_names[0] = "flat_6x3";
        tests[0] = '{w_m1: 14'd5,  h_m1: 14'd2, kind: KIND_FLAT,  param: 8'd100, extra: 4'd0};
        test_names[1] = "hramp_up";
        tests[1] = '{w_m1: 14'd7,  h_m1: 14'd3, kind: KIND_HRAMP, param: 8'd13,  extra: 4'd2};
        test_names[2] = "vramp_down";
        tests[2] = '{w_m1: 14'd6,  h_m1: 14'd4, kind: KIND_VRAMP, param: 8'd219, extra: 4'd0};
        test_names[3] = "hramp_down";
        tests[3] = '{w_m1: 14'd10, h_m1: 14'd2, kind: KIND_HRAMP, param: 8'd253, extra: 4'd1};
        test_names[4] = "random_w5";
        tests[4] = '{w_m1: 14'd4,  h_m1: 14'd5, kind: KIND_RAND,  param: 8'd0,   extra: 4'd3};
        test_names[5] = "random_w9";
        tests[5] = '{w_m1: 14'd8,  h_m1: 14'd6, kind: KIND_RAND,  param: 8'd0,   extra: 4'd1};
        test_names[6] = "narrow_w3";
        tests[6] = '{w_m1: 14'd2,  h_m1: 14'd3, kind: KIND_RAND,  param: 8'd0,   extra: 4'd2};
        test_names[7] = "single_row";
        tests[7] = '{w_m1: 14'd11, h_m1: 14'd0, kind: KIND_RAND,  param: 8'd0,   extra: 4'd4};

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        run_pre_sof();
        for (int n = 0; n < NUM_TESTS; n++) run_test(n);

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/jls_context_modeler.sv */
// Top of the JPEG-LS context modeling front end.
// Chains raster counter, neighbour window, quantizer and error stage.
// One result per accepted pixel, 4 cycles after its i_valid, no stalls.
// o_res.last marks the final pixel of each image.

`timescale 1ns/1ps
`default_nettype none

module jls_context_modeler
    import jls_pkg::*;
(
    input  wire                clk,
    input  wire                reset,
    input  wire                i_sof,
    input  wire  [COORD_W-1:0] i_w,
    input  wire  [COORD_W-1:0] i_h,
    input  wire                i_valid,
    input  wire  [PIXEL_W-1:0] i_x,
    output logic               o_valid,
    output ctx_result_t        o_res
);

    //------------------------------------------------------------
    // stage links
    //------------------------------------------------------------
    logic [COORD_W-1:0] rd_col;     // early column for the line buffer read
    logic               pos_valid;
    pixel_pos_t         pos;
    logic               nb_valid;
    neighbours_t        nb;
    logic               ctx_valid;
    ctx_tagged_t        ctx;

    // cycle 1, position tags
    jls_raster_counter u_raster (
        .clk     (clk),
        .reset   (reset),
        .i_sof   (i_sof),
        .i_w     (i_w),
        .i_h     (i_h),
        .i_valid (i_valid),
        .i_x     (i_x),
        .o_col   (rd_col),
        .o_valid (pos_valid),
        .o_pos   (pos)
    );

    // cycle 2, neighbours
    jls_context_window u_window (
        .clk      (clk),
        .reset    (reset),
        .i_rd_col (rd_col),
        .i_valid  (pos_valid),
        .i_pos    (pos),
        .o_valid  (nb_valid),
        .o_nb     (nb)
    );

    // cycle 3, context
    jls_context_quantizer u_quant (
        .clk     (clk),
        .reset   (reset),
        .i_valid (nb_valid),
        .i_nb    (nb),
        .o_valid (ctx_valid),
        .o_ctx   (ctx)
    );

    // cycle 4, error
    jls_prediction_error u_error (
        .clk     (clk),
        .reset   (reset),
        .i_valid (ctx_valid),
        .i_ctx   (ctx),
        .o_valid (o_valid),
        .o_res   (o_res)
    );

endmodule

`default_nettype wire

/* design/jls_context_quantizer.sv */
// Context quantizer for the third stage of the context modeler.
// Maps the gradients d-b, b-c and c-a to -4..4 with the lossless
// thresholds and folds them into a context magnitude and sign.

`timescale 1ns/1ps
`default_nettype none

module jls_context_quantizer
    import jls_pkg::*;
(
    input  wire                clk,
    input  wire                reset,
    input  wire                i_valid,
    input  wire  neighbours_t  i_nb,
    output logic               o_valid,
    output ctx_tagged_t        o_ctx
);

    // one gradient into the range -4..4
    function automatic logic signed [3:0] quant_grad(
        input logic [PIXEL_W-1:0] hi,
        input logic [PIXEL_W-1:0] lo
    );
        logic signed [PIXEL_W:0] grad;
        logic        [PIXEL_W:0] mag;
        logic signed [3:0]       qv;
        grad = $signed({1'b0, hi}) - $signed({1'b0, lo});
        mag  = grad[PIXEL_W] ? -grad : grad;   // at most 255
        if (mag == '0) begin
            qv = 4'sd0;
        end else if (mag < GRAD_T1) begin
            qv = 4'sd1;
        end else if (mag < GRAD_T2) begin
            qv = 4'sd2;
        end else if (mag < GRAD_T3) begin
            qv = 4'sd3;
        end else begin
            qv = 4'sd4;
        end
        return grad[PIXEL_W] ? -qv : qv;
    endfunction

    logic signed [3:0]     q1;
    logic signed [3:0]     q2;
    logic signed [3:0]     q3;
    logic signed [CTX_W:0] ctx_s;    // -364..364
    logic        [CTX_W:0] ctx_mag;
    logic                  ctx_neg;

    assign q1 = quant_grad(i_nb.d, i_nb.b);
    assign q2 = quant_grad(i_nb.b, i_nb.c);
    assign q3 = quant_grad(i_nb.c, i_nb.a);

    assign ctx_s   = (CTX_W+1)'(81 * q1 + 9 * q2 + q3);
    assign ctx_neg = ctx_s[CTX_W];
    assign ctx_mag = ctx_neg ? -ctx_s : ctx_s;   // fold negative contexts

    //------------------------------------------------------------
    // stage register
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_ctx.x    <= i_nb.x;
            o_ctx.a    <= i_nb.a;
            o_ctx.b    <= i_nb.b;
            o_ctx.c    <= i_nb.c;
            o_ctx.q    <= ctx_mag[CTX_W-1:0];
            o_ctx.sign <= ctx_neg;
            o_ctx.last <= i_nb.last;
        end
    end

endmodule

`default_nettype wire

/* design/jls_context_window.sv */
// Neighbour window, second stage of the context modeler.
// Holds one row of pixels and forms a, b, c, d for each pixel with the
// JPEG-LS edge substitutions. The row-above read is issued one cycle early
// from the raster counter's column, so the data meets the tagged pixel.

`timescale 1ns/1ps
`default_nettype none

module jls_context_window
    import jls_pkg::*;
(
    input  wire                clk,
    input  wire                reset,
    input  wire  [COORD_W-1:0] i_rd_col,   // column of the pixel one cycle ahead
    input  wire                i_valid,
    input  wire  pixel_pos_t   i_pos,
    output logic               o_valid,
    output neighbours_t        o_nb
);

    logic [PIXEL_W-1:0] line_buf [LINE_DEPTH];

    logic [COORD_W-1:0] rd_addr;
    logic [PIXEL_W-1:0] up_next;     // row above at col+1
    logic [PIXEL_W-1:0] up_cur;      // row above at col, last cycle's up_next
    logic [PIXEL_W-1:0] prev_x;      // left neighbour
    logic [PIXEL_W-1:0] prev_b;      // b of the left neighbour
    logic [PIXEL_W-1:0] fc_x;        // first pixel of the previous row
    logic [PIXEL_W-1:0] fc_b;        // b used by the previous row's first pixel
    logic [PIXEL_W-1:0] nb_a;
    logic [PIXEL_W-1:0] nb_b;
    logic [PIXEL_W-1:0] nb_c;
    logic [PIXEL_W-1:0] nb_d;
    logic               expect_fc;   // previous pixel closed a row

    //------------------------------------------------------------
    // line buffer
    //------------------------------------------------------------
    // read one column ahead, b then comes from the previous read
    assign rd_addr = i_rd_col + 1'b1;   // wraps past the last column, d is replaced there

    always_ff @(posedge clk) begin
        up_next <= line_buf[rd_addr];
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            line_buf[i_pos.col] <= i_pos.x;   // never the column being read
        end
    end

    //------------------------------------------------------------
    // edge substitutions
    //------------------------------------------------------------
    always_comb begin
        // b, first column has no earlier read so take the saved pixel
        if (i_pos.first_row) begin
            nb_b = '0;
        end else if (i_pos.first_col) begin
            nb_b = fc_x;
        end else begin
            nb_b = up_cur;
        end
        nb_a = i_pos.first_col ? nb_b : prev_x;
        // c
        if (i_pos.first_row) begin
            nb_c = '0;
        end else if (i_pos.first_col) begin
            nb_c = fc_b;
        end else begin
            nb_c = prev_b;
        end
        // d
        if (i_pos.first_row) begin
            nb_d = '0;
        end else if (i_pos.last_col) begin
            nb_d = nb_b;
        end else begin
            nb_d = up_next;
        end
    end

    // history registers, only move with a pixel
    always_ff @(posedge clk) begin
        if (i_valid) begin
            prev_x <= i_pos.x;
            prev_b <= nb_b;
            up_cur <= up_next;
            if (i_pos.first_col) begin
                fc_x <= i_pos.x;
                fc_b <= nb_b;
            end
        end
    end

    //------------------------------------------------------------
    // outputs
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            o_valid   <= 1'b0;
            expect_fc <= 1'b0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                expect_fc <= i_pos.last_col;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_nb.x    <= i_pos.x;
            o_nb.a    <= nb_a;
            o_nb.b    <= nb_b;
            o_nb.c    <= nb_c;
            o_nb.d    <= nb_d;
            o_nb.last <= i_pos.last;
        end
    end

    // the window history assumes rows arrive whole, in raster order
    a_row_wraps_to_first_col : assert property (@(posedge clk) disable iff (reset)
        (i_valid && expect_fc) |-> i_pos.first_col)
        else $error("pixel after a last column is not a first column");

endmodule

`default_nettype wire

/* design/jls_pkg.sv */
// Shared constants and pipeline records for the JPEG-LS context modeler.
// Every stage of the modeler imports this package with a wildcard import.
// Lossless only, so the gradient thresholds are the fixed default values.

`default_nettype none

package jls_pkg;

    //------------------------------------------------------------
    // image geometry
    //------------------------------------------------------------
    localparam int unsigned COORD_W    = 14;    // column / row count width
    localparam int unsigned PIXEL_W    = 8;
    localparam int unsigned LINE_DEPTH = 16384; // one row of up to 16384 pixels

    // narrowest accepted width-1, smaller i_w is raised to this
    localparam logic [COORD_W-1:0] MIN_W_M1 = COORD_W'(4);

    //------------------------------------------------------------
    // gradient quantizer
    //------------------------------------------------------------
    localparam int GRAD_T1 = 3;
    localparam int GRAD_T2 = 7;
    localparam int GRAD_T3 = 21;

    localparam int          CTX_MAX = 364;  // 81*4 + 9*4 + 4
    localparam int unsigned CTX_W   = 9;

    //------------------------------------------------------------
    // error modulo reduction
    //------------------------------------------------------------
    localparam int ERR_RANGE = 256;
    localparam int ERR_HALF  = 128;

    //------------------------------------------------------------
    // stage records
    //------------------------------------------------------------
    // raster counter output
    typedef struct packed {
        logic [PIXEL_W-1:0] x;
        logic [COORD_W-1:0] col;        // doubles as line buffer write address
        logic               first_col;
        logic               last_col;
        logic               first_row;
        logic               last;       // final pixel of the image
    } pixel_pos_t;

    // current pixel with its causal neighbours
    typedef struct packed {
        logic [PIXEL_W-1:0] x;
        logic [PIXEL_W-1:0] a;          // left
        logic [PIXEL_W-1:0] b;          // above
        logic [PIXEL_W-1:0] c;          // above left
        logic [PIXEL_W-1:0] d;          // above right
        logic               last;
    } neighbours_t;

    // quantizer output, d is no longer needed
    typedef struct packed {
        logic [PIXEL_W-1:0] x;
        logic [PIXEL_W-1:0] a;
        logic [PIXEL_W-1:0] b;
        logic [PIXEL_W-1:0] c;
        logic [CTX_W-1:0]   q;          // context magnitude 0..364
        logic               sign;       // context was negative
        logic               last;
    } ctx_tagged_t;

    // per-pixel result
    typedef struct packed {
        logic [CTX_W-1:0]          q;
        logic                      sign;
        logic signed [PIXEL_W-1:0] errval;  // -128..127
        logic                      last;
    } ctx_result_t;

endpackage

`default_nettype wire

/* design/jls_prediction_error.sv */
// Prediction error, last stage of the context modeler.
// Median edge detector prediction from a, b, c, then the error x-Px is
// negated for negative contexts and folded modulo 256 into -128..127.

`timescale 1ns/1ps
`default_nettype none

module jls_prediction_error
    import jls_pkg::*;
(
    input  wire                clk,
    input  wire                reset,
    input  wire                i_valid,
    input  wire  ctx_tagged_t  i_ctx,
    output logic               o_valid,
    output ctx_result_t        o_res
);

    // MED, picks min/max on edges, else the planar value
    function automatic logic [PIXEL_W-1:0] med_predict(
        input logic [PIXEL_W-1:0] a,
        input logic [PIXEL_W-1:0] b,
        input logic [PIXEL_W-1:0] c
    );
        logic [PIXEL_W-1:0] mx;
        logic [PIXEL_W-1:0] mn;
        mx = (a > b) ? a : b;
        mn = (a > b) ? b : a;
        if (c >= mx) begin
            return mn;
        end else if (c <= mn) begin
            return mx;
        end else begin
            return a + b - c;         // c sits between a and b, no overflow
        end
    endfunction

    logic [PIXEL_W-1:0]        px;
    logic signed [PIXEL_W+1:0] err_raw;   // -255..255 plus headroom
    logic signed [PIXEL_W+1:0] err_sgn;
    logic signed [PIXEL_W+1:0] err_mod;

    assign px      = med_predict(i_ctx.a, i_ctx.b, i_ctx.c);
    assign err_raw = $signed({2'b00, i_ctx.x}) - $signed({2'b00, px});
    assign err_sgn = i_ctx.sign ? -err_raw : err_raw;

    //------------------------------------------------------------
    // modulo reduction
    //------------------------------------------------------------
    always_comb begin
        err_mod = err_sgn;
        if (err_mod < 0) begin
            err_mod = err_mod + (PIXEL_W+2)'(ERR_RANGE);
        end
        if (err_mod >= (PIXEL_W+2)'(ERR_HALF)) begin
            err_mod = err_mod - (PIXEL_W+2)'(ERR_RANGE);
        end
    end

    //------------------------------------------------------------
    // stage register
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_res.q      <= i_ctx.q;
            o_res.sign   <= i_ctx.sign;
            o_res.errval <= err_mod[PIXEL_W-1:0];   // already in -128..127
            o_res.last   <= i_ctx.last;
        end
    end

endmodule

`default_nettype wire

/* design/jls_raster_counter.sv */
// Raster position tracker, first stage of the context modeler.
// Latches the image size on i_sof and tags every accepted pixel with
// its edge flags. Pixels after the last row are dropped here.
// o_col is combinational and feeds the line buffer read address.

`timescale 1ns/1ps
`default_nettype none

module jls_raster_counter
    import jls_pkg::*;
(
    input  wire                clk,
    input  wire                reset,
    input  wire                i_sof,     // start of image, carries i_w / i_h
    input  wire  [COORD_W-1:0] i_w,       // width-1
    input  wire  [COORD_W-1:0] i_h,       // height-1
    input  wire                i_valid,
    input  wire  [PIXEL_W-1:0] i_x,
    output logic [COORD_W-1:0] o_col,     // column of the incoming pixel
    output logic               o_valid,
    output pixel_pos_t         o_pos
);

    logic [COORD_W-1:0] w_m1;
    logic [COORD_W-1:0] h_m1;
    logic [COORD_W-1:0] col_cnt;
    logic [COORD_W:0]   row_cnt;      // extra msb so a row past the end fits
    logic               accept;
    logic               at_last_col;
    logic               at_last_row;

    assign at_last_col = (col_cnt == w_m1);
    assign at_last_row = (row_cnt == {1'b0, h_m1});
    assign accept      = i_valid && (row_cnt <= {1'b0, h_m1});  // drop trailing pixels
    assign o_col       = col_cnt;

    //------------------------------------------------------------
    // position counters
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            w_m1    <= MIN_W_M1;
            h_m1    <= '0;
            col_cnt <= '0;
            row_cnt <= '1;                // past the end until the first i_sof
        end else if (i_sof) begin
            w_m1    <= (i_w < MIN_W_M1) ? MIN_W_M1 : i_w;
            h_m1    <= i_h;
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (accept) begin
            if (at_last_col) begin
                col_cnt <= '0;
                row_cnt <= row_cnt + 1'b1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    //------------------------------------------------------------
    // tagged pixel out
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_pos.x         <= i_x;
            o_pos.col       <= col_cnt;
            o_pos.first_col <= (col_cnt == '0);
            o_pos.last_col  <= at_last_col;
            o_pos.first_row <= (row_cnt == '0);
            o_pos.last      <= at_last_col && at_last_row;
        end
    end

    // the source may not send a pixel in the i_sof cycle
    a_no_pixel_on_sof : assert property (@(posedge clk) disable iff (reset)
        !(i_valid && i_sof))
        else $error("pixel strobed together with i_sof");

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the context modeler testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_jls_context_modeler
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        -f vlog.f --top-module "$TOP" -Mdir obj_dir -o "sim_$TOP"; then
    echo "verilator build failed"
    exit 1
fi

if ! "./obj_dir/sim_$TOP" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error, see $LOG"
    exit 1
fi

cat "$LOG"
if grep -q "TESTBENCH PASSED" "$LOG"; then
    exit 0
fi
echo "pass message missing from $LOG"
exit 1

/* vlog.f */
+incdir+include
design/jls_pkg.sv
design/jls_raster_counter.sv
design/jls_context_window.sv
design/jls_context_quantizer.sv
design/jls_prediction_error.sv
design/jls_context_modeler.sv
bench/tb_jls_context_modeler.sv
